// File: forth_soc.f
+incdir+sim
hw/forth_pkg.sv
hw/bus_pkg.sv
hw/stack_lifo.sv
hw/core_timer.sv
hw/forth_cpu.sv
hw/bus_fabric.sv
hw/forth_soc.sv
sim/tb_forth_soc.sv

// File: hw/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric (
    input  logic              clk,
    input  logic              arst_n,
    input  bus_pkg::bus_req_t bus_req,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic              led,
    output forth_pkg::word_t  port_data,
    output logic              port_strobe
);
    import forth_pkg::*;
    import bus_pkg::*;

    word_t                ram [2**RAM_BITS];
    logic [15-SEL_LSB:0]  sel;
    logic [RAM_BITS-1:0]  ram_addr;
    logic [PORT_BITS-1:0] port_num;
    logic                 ram_sel, port_sel, wr;
    logic                 led_wr, out_wr;
    word_t                port_rdata;
    word_t                rdata_q;
    logic                 ready_q;

    assign sel      = bus_req.addr[15:SEL_LSB];
    assign ram_addr = bus_req.addr[RAM_BITS-1:0];
    assign port_num = bus_req.addr[PORT_BITS-1:0];
    assign ram_sel  = (sel == SEL_RAM);
    assign port_sel = (sel == SEL_PORTS);
    assign wr       = bus_req.valid && bus_req.write;
    assign led_wr   = wr && port_sel && (port_num == PORT_LED);
    assign out_wr   = wr && port_sel && (port_num == PORT_OUT);

    always_comb begin
        port_rdata = '0;
        if (port_num == PORT_LED)
            port_rdata = word_t'(led);
        else if (port_num == PORT_OUT)
            port_rdata = port_data;
    end

    // Reads see the value from before a write in the same cycle
    always_ff @(posedge clk) begin
        if (wr && ram_sel)
            ram[ram_addr] <= bus_req.wdata;
        if (bus_req.valid) begin
            if (ram_sel)
                rdata_q <= ram[ram_addr];
            else if (port_sel)
                rdata_q <= port_rdata;
            else
                rdata_q <= '0;  // Unmapped region
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q     <= 1'b0;
            led         <= 1'b0;
            port_data   <= '0;
            port_strobe <= 1'b0;
        end else begin
            ready_q     <= bus_req.valid;
            port_strobe <= out_wr;
            if (led_wr)
                led <= bus_req.wdata[0];
            if (out_wr)
                port_data <= bus_req.wdata;
        end
    end

    assign bus_rsp.ready = ready_q;
    assign bus_rsp.rdata = rdata_q;

    assert property (@(posedge clk) disable iff (!arst_n) bus_rsp.ready == $past(bus_req.valid));

endmodule

// File: hw/bus_pkg.sv
package bus_pkg;

    // ##################################################
    // Address map
    // Bits 15:13 select the region. RAM sits at 0x0000, ports at 0xE000

    localparam int SEL_LSB = 13;

    localparam logic [15-SEL_LSB:0] SEL_RAM   = 3'd0;
    localparam logic [15-SEL_LSB:0] SEL_PORTS = 3'd7;

    // Port number is taken from the low address bits of the port region
    localparam int PORT_BITS = 4;

    localparam logic [PORT_BITS-1:0] PORT_LED = 4'd0;
    localparam logic [PORT_BITS-1:0] PORT_OUT = 4'd1;

    // ##################################################
    // Bus transfer

    typedef struct packed {
        logic              valid;
        logic              write;
        forth_pkg::word_t  addr;
        forth_pkg::word_t  wdata;
    } bus_req_t;

    typedef struct packed {
        logic              ready;
        forth_pkg::word_t  rdata;
    } bus_rsp_t;

endpackage

// File: hw/core_timer.sv
`timescale 1ns/1ps

module core_timer (
    input  logic clk,
    input  logic arst_n,
    output logic tick,
    output logic core_rst,
    output logic wake
);
    import forth_pkg::*;

    localparam int DIV_W  = $clog2(CLK_DIV);
    localparam int RST_W  = $clog2(RESET_TICKS + 1);
    localparam int WAKE_W = $clog2(WAKE_TICKS);

    logic [DIV_W-1:0]  div_cnt;
    logic [RST_W-1:0]  rst_cnt;
    logic [WAKE_W-1:0] wake_cnt;

    assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign core_rst = (rst_cnt != RST_W'(RESET_TICKS));  // Stays low once the count is reached
    assign wake     = tick && (wake_cnt == WAKE_W'(WAKE_TICKS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt  <= '0;
            rst_cnt  <= '0;
            wake_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick && core_rst)
                rst_cnt <= rst_cnt + 1'b1;
            if (tick)
                wake_cnt <= wake ? '0 : wake_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) tick |=> !tick);

endmodule

// File: hw/forth_cpu.sv
`timescale 1ns/1ps

module forth_cpu (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    tick,
    input  logic                    core_rst,
    input  logic                    wake,
    output bus_pkg::bus_req_t       bus_req,
    input  bus_pkg::bus_rsp_t       bus_rsp,
    output forth_pkg::core_status_t status
);
    import forth_pkg::*;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_BUS_WAIT,
        S_WAIT_WAKE,
        S_STOP
    } state_e;

    state_e    state;
    rom_addr_t pc;
    word_t     ir;
    word_t     t_q;       // Top of the data stack, the LIFO holds everything below it
    logic      t_valid;
    logic      err;

    word_t     rom [2**ROM_BITS];

    logic      ds_push, ds_pop, ds_overflow, ds_underflow;
    word_t     ds_top, ds_next;
    logic      rs_push, rs_pop, rs_overflow, rs_underflow;
    rom_addr_t rs_top;

    logic      is_lit, illegal, exec_tick, bus_tick;
    logic      need_t, drop_like, mem_op, fault;
    opcode_e   op;
    rom_addr_t target;

    initial $readmemh("program.hex", rom);

    assign is_lit    = ir[15];
    assign op        = opcode_e'(ir[14:10]);
    assign target    = ir[ROM_BITS-1:0];
    assign illegal   = !is_lit && (ir[14:10] > 5'(OP_HLT));
    assign exec_tick = tick && (state == S_EXEC);
    assign bus_tick  = tick && (state == S_BUS_WAIT);
    assign drop_like = !is_lit && (op == OP_DROP || op == OP_JZ);
    assign mem_op    = !is_lit && (op == OP_FETCH || op == OP_STORE);

    // ##################################################
    // Stack control

    always_comb begin
        ds_push = 1'b0;
        ds_pop  = 1'b0;
        rs_push = 1'b0;
        rs_pop  = 1'b0;
        need_t  = 1'b0;
        if (exec_tick && is_lit) begin
            ds_push = t_valid;  // Old top moves down into the LIFO
        end else if (exec_tick) begin
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_DROP, OP_JZ, OP_STORE: begin
                    need_t = 1'b1;
                    ds_pop = 1'b1;
                end
                OP_DUP: begin
                    need_t  = 1'b1;
                    ds_push = 1'b1;
                end
                OP_SWAP: begin
                    need_t  = 1'b1;
                    ds_push = 1'b1;
                    ds_pop  = 1'b1;
                end
                OP_FETCH: need_t = 1'b1;
                OP_CALL:  rs_push = 1'b1;
                OP_RET:   rs_pop = 1'b1;
                default: ;
            endcase
        end else if (bus_tick && op == OP_STORE) begin
            ds_pop = 1'b1;  // Drops the copy of the new top left by the first pop
        end
    end

    // An empty LIFO on DROP or JZ only means the last entry went away
    assign fault = exec_tick && (illegal || (need_t && !t_valid) || ds_overflow
                   || rs_overflow || rs_underflow || (ds_underflow && !drop_like));

    assign bus_req.valid = exec_tick && mem_op && !fault;
    assign bus_req.write = (op == OP_STORE);
    assign bus_req.addr  = t_q;
    assign bus_req.wdata = ds_top;

    assign status.error   = err;
    assign status.halted  = (state == S_STOP) && !err;
    assign status.waiting = (state == S_WAIT_WAKE);

    // ##################################################
    // Sequencer

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_FETCH;
            pc      <= '0;
            t_valid <= 1'b0;
            err     <= 1'b0;
        end else if (core_rst) begin
            state   <= S_FETCH;
            pc      <= '0;
            t_valid <= 1'b0;
            err     <= 1'b0;
        end else if (tick) begin
            case (state)
                S_FETCH: begin
                    pc    <= pc + 1'b1;
                    state <= S_EXEC;
                end
                S_EXEC: begin
                    state <= S_FETCH;
                    if (fault) begin
                        err   <= 1'b1;
                        state <= S_STOP;
                    end else if (is_lit) begin
                        t_valid <= 1'b1;
                    end else begin
                        case (op)
                            OP_FETCH, OP_STORE: state <= S_BUS_WAIT;
                            OP_DROP: if (ds_underflow) t_valid <= 1'b0;
                            OP_JZ: begin
                                if (ds_underflow)
                                    t_valid <= 1'b0;
                                if (t_q == '0)
                                    pc <= target;
                            end
                            OP_JMP, OP_CALL: pc <= target;
                            OP_RET:  pc <= rs_top;
                            OP_WFI:  state <= S_WAIT_WAKE;
                            OP_HLT:  state <= S_STOP;
                            default: ;
                        endcase
                    end
                end
                S_BUS_WAIT: begin
                    if (op == OP_STORE && ds_underflow)
                        t_valid <= 1'b0;
                    state <= S_FETCH;
                end
                S_WAIT_WAKE: if (wake) state <= S_FETCH;
                default: ;  // STOP is left only through arst_n
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tick && state == S_FETCH)
            ir <= rom[pc];
        if (exec_tick) begin
            if (is_lit) begin
                t_q <= {1'b0, ir[14:0]};
            end else begin
                case (op)
                    OP_ADD:  t_q <= ds_top + t_q;
                    OP_SUB:  t_q <= ds_top - t_q;
                    OP_AND:  t_q <= ds_top & t_q;
                    OP_XOR:  t_q <= ds_top ^ t_q;
                    OP_DROP, OP_JZ, OP_SWAP: t_q <= ds_top;
                    OP_STORE: t_q <= ds_next;
                    default: ;
                endcase
            end
        end
        if (state == S_BUS_WAIT && bus_rsp.ready && op == OP_FETCH)
            t_q <= bus_rsp.rdata;
    end

    stack_lifo #(.entry_t(word_t), .DEPTH(DSTACK_DEPTH)) i_dstack (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (ds_push),
        .pop       (ds_pop),
        .wdata     (t_q),
        .top       (ds_top),
        .next      (ds_next),
        .overflow  (ds_overflow),
        .underflow (ds_underflow)
    );

    stack_lifo #(.entry_t(rom_addr_t), .DEPTH(RSTACK_DEPTH)) i_rstack (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (rs_push),
        .pop       (rs_pop),
        .wdata     (pc),
        .top       (rs_top),
        .next      (),
        .overflow  (rs_overflow),
        .underflow (rs_underflow)
    );

    // One request per bus state, and the core is already waiting when it goes out
    assert property (@(posedge clk) disable iff (!arst_n)
        bus_req.valid |=> (state == S_BUS_WAIT) && !bus_req.valid);

endmodule

// File: hw/forth_pkg.sv
package forth_pkg;

    // ##################################################
    // Core geometry

    localparam int ROM_BITS     = 8;
    localparam int RAM_BITS     = 8;
    localparam int DSTACK_DEPTH = 16;
    localparam int RSTACK_DEPTH = 8;

    localparam int CLK_DIV     = 4;   // clk cycles per core tick
    localparam int RESET_TICKS = 8;   // Ticks before the core leaves reset
    localparam int WAKE_TICKS  = 32;  // Ticks between wake pulses

    typedef logic [15:0]         word_t;
    typedef logic [ROM_BITS-1:0] rom_addr_t;

    // ##################################################
    // Instruction set
    // Bit 15 set pushes bits 14:0 as a zero-extended literal.
    // Otherwise bits 14:10 hold the opcode and bits 7:0 a ROM target

    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ADD   = 5'd1,
        OP_SUB   = 5'd2,
        OP_AND   = 5'd3,
        OP_XOR   = 5'd4,
        OP_DUP   = 5'd5,
        OP_DROP  = 5'd6,
        OP_SWAP  = 5'd7,
        OP_FETCH = 5'd8,   // ( addr -- value )
        OP_STORE = 5'd9,   // ( value addr -- )
        OP_JMP   = 5'd10,
        OP_JZ    = 5'd11,  // Consumes the flag
        OP_CALL  = 5'd12,
        OP_RET   = 5'd13,
        OP_WFI   = 5'd14,
        OP_HLT   = 5'd15
    } opcode_e;

    typedef struct packed {
        logic error;
        logic halted;
        logic waiting;
    } core_status_t;

endpackage

// File: hw/forth_soc.sv
`timescale 1ns/1ps

module forth_soc (
    input  logic             clk,
    input  logic             arst_n,
    output logic             nerror,
    output logic             nhlt,
    output logic             nwfi,
    output logic             led,
    output forth_pkg::word_t port_data,
    output logic             port_strobe
);
    import forth_pkg::*;
    import bus_pkg::*;

    logic         tick;
    logic         core_rst;
    logic         wake;
    bus_req_t     bus_req;
    bus_rsp_t     bus_rsp;
    core_status_t status;

    core_timer i_core_timer (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .core_rst (core_rst),
        .wake     (wake)
    );

    forth_cpu i_forth_cpu (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .core_rst (core_rst),
        .wake     (wake),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .status   (status)
    );

    bus_fabric i_bus_fabric (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .led         (led),
        .port_data   (port_data),
        .port_strobe (port_strobe)
    );

    // Status pins are active low
    assign nerror = !status.error;
    assign nhlt   = !status.halted;
    assign nwfi   = !status.waiting;

endmodule

// File: hw/stack_lifo.sv
`timescale 1ns/1ps

module stack_lifo #(
    parameter type entry_t = forth_pkg::word_t,
    parameter int  DEPTH   = 16
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   push,
    input  logic   pop,
    input  entry_t wdata,
    output entry_t top,
    output entry_t next,
    output logic   overflow,
    output logic   underflow
);
    localparam int PTR_W = $clog2(DEPTH + 1);
    localparam int IDX_W = $clog2(DEPTH);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] ptr;  // Number of entries held
    logic [IDX_W-1:0] top_idx;
    logic [IDX_W-1:0] next_idx;
    logic [IDX_W-1:0] wr_idx;

    assign top_idx   = IDX_W'(ptr - 1'b1);
    assign next_idx  = IDX_W'(ptr - 2'd2);
    assign wr_idx    = pop ? top_idx : IDX_W'(ptr);  // Push with pop overwrites the top
    assign top       = mem[top_idx];
    assign next      = mem[next_idx];

    assign underflow = pop && (ptr == '0);
    assign overflow  = push && !pop && (ptr == PTR_W'(DEPTH));

    // A faulting request leaves the stack untouched
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
        end else if (!overflow && !underflow) begin
            if (push && !pop)
                ptr <= ptr + 1'b1;
            else if (pop && !push)
                ptr <= ptr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !overflow && !underflow)
            mem[wr_idx] <= wdata;
    end

    assert property (@(posedge clk) disable iff (!arst_n) ptr <= PTR_W'(DEPTH));

endmodule

// File: program.hex
// Program ROM image, 16-bit instruction words in hex from address 0, several per line.
// Bit 15 set is a literal, otherwise bits 14:10 are the opcode and bits 7:0 a ROM target.
8020 2000 9234 1000 2C4A                // 00 Marker at RAM 0x20 selects the second region
F000 1400 0400 1400 8011 2400           // 05 RAM 0x11 holds the LED port address
8001 0400 8010 2400                     // 0B RAM 0x10 holds the OUT port address
8123 8045 0400 3046                     // 0F Write 0x123 plus 0x45
8100 8001 0800 80F0 0C00 85A5 1000 3046 // 13 Write ((0x100 minus 1) and 0xF0) xor 0x5A5
8007 8003 1C00 0800 1400 1800 3046      // 1B Swap, then 3 minus 7, dup and drop
8ABC 8042 2400 8042 2000 3046           // 22 RAM store and fetch back
A000 2000 8010 2000 2000 0400 8001 0400 3046 // 28 Unmapped read plus port readback plus 1
8003                                    // 31 Loop counter
1400 3046 8001 0800 1400 2C3A 2832      // 32 Loop writes the count down to 1
7C00                                    // 39 Trap that the jump skips
1800 3800 8777 3046                     // 3A Wait for a wake, then write
8001 8011 2000 2400                     // 3E Turn the LED on
9234 8020 2400 3C00                     // 42 Leave the marker and halt
8010 2000 2400 3400                     // 46 Subroutine that writes the top word to OUT
8BAD 3046 4000 3C00                     // 4A Second region ends in an illegal opcode

// File: run_sim.sh
#!/bin/sh
# Build the forth_soc testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_forth_soc -f forth_soc.f -o tb_forth_soc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_forth_soc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: sim/forth_model.svh
`ifndef FORTH_MODEL_SVH
`define FORTH_MODEL_SVH

// ##################################################
// Instruction-level model of the program in program.hex

word_t exp_writes [$];  // Port writes still expected, oldest first
logic  exp_led;
int    exp_steps;
int    exp_waits;
word_t out_reg;
word_t prog_rom [2**ROM_BITS];
word_t sim_ram  [2**RAM_BITS];  // Kept across runs, like the RAM in the design

function automatic word_t read_mapped(input word_t addr);
    word_t value;
    value = '0;  // Unmapped regions and unused ports read zero
    if (addr[15:SEL_LSB] == SEL_RAM)
        value = sim_ram[addr[RAM_BITS-1:0]];
    else if (addr[15:SEL_LSB] == SEL_PORTS && addr[PORT_BITS-1:0] == PORT_LED)
        value = word_t'(exp_led);
    else if (addr[15:SEL_LSB] == SEL_PORTS && addr[PORT_BITS-1:0] == PORT_OUT)
        value = out_reg;
    return value;
endfunction

function automatic void write_mapped(input word_t addr, input word_t data);
    if (addr[15:SEL_LSB] == SEL_RAM) begin
        sim_ram[addr[RAM_BITS-1:0]] = data;
    end else if (addr[15:SEL_LSB] == SEL_PORTS && addr[PORT_BITS-1:0] == PORT_LED) begin
        exp_led = data[0];
    end else if (addr[15:SEL_LSB] == SEL_PORTS && addr[PORT_BITS-1:0] == PORT_OUT) begin
        out_reg = data;
        exp_writes.push_back(data);
    end
endfunction

// Runs the program from address 0 until HLT or a fault
function automatic core_status_t run_model();
    word_t        ds [$];
    rom_addr_t    rs [$];
    rom_addr_t    pc;
    word_t        instr;
    word_t        a;
    word_t        b;
    logic [4:0]   opc;
    int           need;
    core_status_t st;

    exp_writes.delete();
    exp_led   = 1'b0;
    out_reg   = '0;
    exp_steps = 0;
    exp_waits = 0;
    pc        = '0;
    st        = '0;
    a         = '0;
    b         = '0;
    while (!st.error && !st.halted && exp_steps < 4096) begin  // Guard against a runaway loop
        instr = prog_rom[pc];
        opc   = instr[14:10];
        pc    = pc + 1'b1;
        exp_steps++;
        case (opc)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SWAP, OP_STORE: need = 2;
            OP_DUP, OP_DROP, OP_FETCH, OP_JZ: need = 1;
            default: need = 0;
        endcase
        if (instr[15]) begin
            ds.push_back({1'b0, instr[14:0]});
            st.error = (ds.size() > DSTACK_DEPTH + 1);  // Top register plus the stack below it
        end else if (opc > 5'(OP_HLT) || ds.size() < need) begin
            st.error = 1'b1;
        end else if (opc == OP_CALL && rs.size() == RSTACK_DEPTH) begin
            st.error = 1'b1;
        end else if (opc == OP_RET && rs.size() == 0) begin
            st.error = 1'b1;
        end else begin
            if (need > 0)
                b = ds.pop_back();
            if (need > 1)
                a = ds.pop_back();
            case (opc)
                OP_ADD:   ds.push_back(a + b);
                OP_SUB:   ds.push_back(a - b);
                OP_AND:   ds.push_back(a & b);
                OP_XOR:   ds.push_back(a ^ b);
                OP_DUP: begin
                    ds.push_back(b);
                    ds.push_back(b);
                    st.error = (ds.size() > DSTACK_DEPTH + 1);
                end
                OP_SWAP: begin
                    ds.push_back(b);
                    ds.push_back(a);
                end
                OP_FETCH: ds.push_back(read_mapped(b));
                OP_STORE: write_mapped(b, a);
                OP_JMP:   pc = instr[ROM_BITS-1:0];
                OP_JZ: begin
                    if (b == '0)
                        pc = instr[ROM_BITS-1:0];
                end
                OP_CALL: begin
                    rs.push_back(pc);
                    pc = instr[ROM_BITS-1:0];
                end
                OP_RET:   pc = rs.pop_back();
                OP_WFI:   exp_waits++;
                OP_HLT:   st.halted = 1'b1;
                default: ;  // NOP and DROP need nothing more
            endcase
        end
    end
    return st;
endfunction

`endif

// File: sim/tb_forth_soc.sv
`timescale 1ns/1ps

module tb_forth_soc;
    import forth_pkg::*;
    import bus_pkg::*;

    logic         clk;
    logic         arst_n;
    logic         nerror;
    logic         nhlt;
    logic         nwfi;
    logic         led;
    word_t        port_data;
    logic         port_strobe;

    int           mismatches;
    int           failures;
    int           wfi_seen;
    int           extra_hold;
    int unsigned  seed_val;
    logic         nwfi_q;
    logic         stopped;
    string        run_name;
    core_status_t exp_status;

    `include "forth_model.svh"

    forth_soc i_forth_soc (
        .clk         (clk),
        .arst_n      (arst_n),
        .nerror      (nerror),
        .nhlt        (nhlt),
        .nwfi        (nwfi),
        .led         (led),
        .port_data   (port_data),
        .port_strobe (port_strobe)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ##################################################
    // Checks

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name, input core_status_t expected,
                                input core_status_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Outputs only change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!arst_n) begin
            wfi_seen = 0;
        end else begin
            if (port_strobe && exp_writes.size() == 0) begin
                failures++;
                $display("%s wrote %h to the port after the last expected write",
                         run_name, port_data);
            end else if (port_strobe) begin
                check_word({run_name, " port write"}, exp_writes.pop_front(), port_data);
            end
            if (nwfi_q && !nwfi)
                wfi_seen++;
        end
        nwfi_q = nwfi;
    end

    task automatic check_final(input core_status_t expected);
        core_status_t actual;
        actual.error   = !nerror;
        actual.halted  = !nhlt;
        actual.waiting = !nwfi;
        if (exp_writes.size() != 0) begin
            failures++;
            $display("%s stopped with %0d port writes never seen", run_name, exp_writes.size());
        end
        check_status({run_name, " final status"}, expected, actual);
        check_word({run_name, " led"}, word_t'(exp_led), word_t'(led));
        check_word({run_name, " wait phases"}, word_t'(exp_waits), word_t'(wfi_seen));
    endtask

    // ##################################################
    // Run control

    task automatic hold_reset(input int cycles);
        arst_n = 1'b0;
        repeat (cycles) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // Worst case is three ticks per instruction plus a full wake period per WFI
    function automatic int cycle_limit();
        return (exp_steps * 3 + exp_waits * (WAKE_TICKS + 1) + RESET_TICKS + 2) * CLK_DIV + 200;
    endfunction

    task automatic wait_for_stop(input int limit, output logic in_time);
        int cycles;
        cycles = 0;
        while (nhlt && nerror && cycles <= limit) begin
            @(negedge clk);
            cycles++;
        end
        in_time = (cycles <= limit);
        if (in_time) begin
            repeat (4) @(negedge clk);
        end else begin
            failures++;
            $display("Timeout: %s neither halted nor faulted within %0d cycles",
                     run_name, limit);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        mismatches = 0;
        failures   = 0;
        extra_hold = 0;
        seed_val   = 32'hc31d1925;
        void'($urandom(seed_val));
        $readmemh("program.hex", prog_rom);
        foreach (sim_ram[i])
            sim_ram[i] = '0;

        // First run goes through the whole program and halts
        run_name   = "run 1";
        exp_status = run_model();
        hold_reset(3);
        wait_for_stop(cycle_limit(), stopped);
        if (stopped)
            check_final(exp_status);

        // The marker left in RAM sends the second run into the faulting region
        run_name   = "run 2";
        extra_hold = $urandom % 5;
        exp_status = run_model();
        hold_reset(3 + extra_hold);
        wait_for_stop(cycle_limit(), stopped);
        if (stopped)
            check_final(exp_status);

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
